//--- logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // **************************************************
  // Widths and pipe depth
  // **************************************************

  localparam int REG_W    = 5;
  localparam int CLASS_W  = 2;
  localparam int LAT_W    = 3;
  localparam int EX_DEPTH = 5;  // Stages in the long EX pipe.

  typedef logic [REG_W-1:0]   reg_idx_t;
  typedef logic [CLASS_W-1:0] instr_class_t;
  typedef logic [LAT_W-1:0]   mem_lat_t;  // Zero behaves like one.

  localparam instr_class_t CLASS_ALU    = 2'd0;
  localparam instr_class_t CLASS_EX     = 2'd1;
  localparam instr_class_t CLASS_MEM    = 2'd2;
  localparam instr_class_t CLASS_BRANCH = 2'd3;

  // **************************************************
  // Descriptors and tags
  // **************************************************

  typedef struct packed {
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    logic         rs1_needed;
    logic         rs2_needed;
    reg_idx_t     rd;
    logic         rd_wr;
    instr_class_t iclass;
    mem_lat_t     mem_lat;
  } dec_instr_t;

  typedef struct packed {
    logic     valid;
    logic     wr;
    reg_idx_t rd;
  } ex_stage_t;

  typedef ex_stage_t [EX_DEPTH-1:0] ex_stages_t;  // Index 0 holds stage 1.

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
  } wb_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WAIT,
    MEM_DONE
  } mem_state_e;

endpackage

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire logic                  dec_valid_i,
  input  wire issue_pkg::dec_instr_t instr_i,
  input  wire issue_pkg::ex_stages_t ex_stages_i,
  input  wire logic                  mem_busy_i,
  input  wire issue_pkg::ex_stage_t  mem_pend_i,
  output logic                       stall_o,
  output logic                       issue_o
);

  logic raw_ex;
  logic raw_mem;
  logic ex_busy;
  logic class_stall;

  // True when a needed source reads the register a pending slot will write.
  function automatic logic src_hit(
    input issue_pkg::reg_idx_t  src,
    input logic                 needed,
    input issue_pkg::ex_stage_t slot
  );
    return needed && (src != '0) && slot.valid && slot.wr && (src == slot.rd);
  endfunction

  // **************************************************
  // Read-after-write checks
  // **************************************************

  always_comb begin : raw_check
    raw_ex = 1'b0;
    // The last stage writes back this cycle, so it is not a hazard.
    for (int s = 0; s < issue_pkg::EX_DEPTH - 1; s++) begin
      raw_ex = raw_ex |
               src_hit(instr_i.rs1, instr_i.rs1_needed, ex_stages_i[s]) |
               src_hit(instr_i.rs2, instr_i.rs2_needed, ex_stages_i[s]);
    end

    raw_mem = src_hit(instr_i.rs1, instr_i.rs1_needed, mem_pend_i) |
              src_hit(instr_i.rs2, instr_i.rs2_needed, mem_pend_i);
  end

  // **************************************************
  // Structural checks per class
  // **************************************************

  always_comb begin : class_check
    ex_busy = 1'b0;
    for (int s = 0; s < issue_pkg::EX_DEPTH; s++) begin
      ex_busy = ex_busy | ex_stages_i[s].valid;
    end

    case (instr_i.iclass)
      issue_pkg::CLASS_BRANCH: begin
        class_stall = ex_busy;                 // Branches wait for an empty EX pipe.
      end
      issue_pkg::CLASS_ALU: begin
        // An EX result in the next to last stage claims the shared port next cycle.
        class_stall = ex_stages_i[issue_pkg::EX_DEPTH-2].valid;
      end
      issue_pkg::CLASS_MEM: begin
        class_stall = mem_busy_i;              // Only one access in flight.
      end
      default: begin
        class_stall = 1'b0;
      end
    endcase
  end

  // **************************************************
  // Decision
  // **************************************************

  always_comb begin : decode_stall
    stall_o = 1'b0;
    if (dec_valid_i && (raw_ex || raw_mem || class_stall)) begin
      stall_o = 1'b1;
    end
  end

  assign issue_o = dec_valid_i && !stall_o;

endmodule : hazard_unit

`default_nettype wire

//--- logic/exec_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tracker (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  issue_i,
  input  wire issue_pkg::dec_instr_t instr_i,
  output issue_pkg::ex_stages_t      ex_stages_o,
  output issue_pkg::wb_t             pipe_wb_o
);

  logic                 alu_issue;
  logic                 ex_issue;
  issue_pkg::ex_stage_t alu_q;
  issue_pkg::ex_stages_t stages_q;
  issue_pkg::ex_stage_t last_stage;

  assign alu_issue = issue_i && (instr_i.iclass == issue_pkg::CLASS_ALU);
  assign ex_issue  = issue_i && (instr_i.iclass == issue_pkg::CLASS_EX);

  // **************************************************
  // Single ALU slot and EX shift register
  // **************************************************

  always_ff @(posedge clk_i) begin
    alu_q       <= '{valid: alu_issue, wr: instr_i.rd_wr, rd: instr_i.rd};
    stages_q[0] <= '{valid: ex_issue, wr: instr_i.rd_wr, rd: instr_i.rd};
    for (int s = 1; s < issue_pkg::EX_DEPTH; s++) begin
      stages_q[s] <= stages_q[s-1];  // The pipe never stalls.
    end

    if (rst_i) begin
      alu_q.valid <= 1'b0;
      for (int s = 0; s < issue_pkg::EX_DEPTH; s++) begin
        stages_q[s].valid <= 1'b0;
      end
    end
  end

  assign last_stage  = stages_q[issue_pkg::EX_DEPTH-1];
  assign ex_stages_o = stages_q;

  // The hazard rules keep both sources from reporting in one cycle.
  always_comb begin : pipe_wb_merge
    pipe_wb_o = '0;
    if (alu_q.valid && alu_q.wr) begin
      pipe_wb_o = '{valid: 1'b1, rd: alu_q.rd};
    end else if (last_stage.valid && last_stage.wr) begin
      pipe_wb_o = '{valid: 1'b1, rd: last_stage.rd};
    end
  end

endmodule : exec_tracker

`default_nettype wire

//--- logic/mem_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_timer (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                load_i,
  input  wire issue_pkg::mem_lat_t lat_i,
  output logic                     last_o
);

  issue_pkg::mem_lat_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= (lat_i == '0) ? issue_pkg::mem_lat_t'(1) : lat_i;
    end else if (count_q != '0) begin
      count_q <= count_q - issue_pkg::mem_lat_t'(1);  // Rests at zero.
    end
  end

  assign last_o = (count_q == issue_pkg::mem_lat_t'(1));  // Final wait cycle.

endmodule : mem_timer

`default_nettype wire

//--- logic/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  issue_i,
  input  wire issue_pkg::dec_instr_t instr_i,
  input  wire logic                  tmr_last_i,
  output logic                       tmr_load_o,
  output issue_pkg::mem_lat_t        tmr_lat_o,
  output logic                       busy_o,
  output issue_pkg::ex_stage_t       pend_o,
  output issue_pkg::wb_t             mem_wb_o
);

  issue_pkg::mem_state_e state_q;
  issue_pkg::mem_state_e state_d;
  logic                  mem_issue;
  issue_pkg::reg_idx_t   pend_rd_q;
  logic                  pend_wr_q;

  assign mem_issue  = issue_i && (instr_i.iclass == issue_pkg::CLASS_MEM);
  assign tmr_load_o = mem_issue;        // Timer starts on the issuing edge.
  assign tmr_lat_o  = instr_i.mem_lat;

  // **************************************************
  // Access FSM
  // **************************************************

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      issue_pkg::MEM_IDLE: begin
        if (mem_issue) begin
          state_d = issue_pkg::MEM_WAIT;
        end
      end
      issue_pkg::MEM_WAIT: begin
        if (tmr_last_i) begin
          state_d = issue_pkg::MEM_DONE;
        end
      end
      issue_pkg::MEM_DONE: begin
        state_d = issue_pkg::MEM_IDLE;  // Busy blocks a new access here.
      end
      default: begin
        state_d = issue_pkg::MEM_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= issue_pkg::MEM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_issue) begin
      pend_rd_q <= instr_i.rd;
      pend_wr_q <= instr_i.rd_wr;
    end
  end

  assign busy_o   = (state_q != issue_pkg::MEM_IDLE);
  assign pend_o   = '{valid: busy_o, wr: pend_wr_q, rd: pend_rd_q};
  assign mem_wb_o = '{valid: (state_q == issue_pkg::MEM_DONE) && pend_wr_q, rd: pend_rd_q};

endmodule : mem_ctrl

`default_nettype wire

//--- logic/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  dec_valid_i,
  input  wire issue_pkg::dec_instr_t instr_i,
  output logic                       stall_o,
  output logic                       issue_o,
  output issue_pkg::wb_t             pipe_wb_o,
  output issue_pkg::wb_t             mem_wb_o
);

  issue_pkg::ex_stages_t ex_stages;
  logic                  mem_busy;
  issue_pkg::ex_stage_t  mem_pend;
  logic                  tmr_load;
  issue_pkg::mem_lat_t   tmr_lat;
  logic                  tmr_last;

  // **************************************************
  // Issue decision
  // **************************************************

  hazard_unit hazard_unit_i (
    .dec_valid_i (dec_valid_i),
    .instr_i     (instr_i),
    .ex_stages_i (ex_stages),
    .mem_busy_i  (mem_busy),
    .mem_pend_i  (mem_pend),
    .stall_o     (stall_o),
    .issue_o     (issue_o)
  );

  // **************************************************
  // Execution paths
  // **************************************************

  exec_tracker exec_tracker_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue_i     (issue_o),
    .instr_i     (instr_i),
    .ex_stages_o (ex_stages),
    .pipe_wb_o   (pipe_wb_o)
  );

  mem_ctrl mem_ctrl_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_o),
    .instr_i    (instr_i),
    .tmr_last_i (tmr_last),
    .tmr_load_o (tmr_load),
    .tmr_lat_o  (tmr_lat),
    .busy_o     (mem_busy),
    .pend_o     (mem_pend),
    .mem_wb_o   (mem_wb_o)
  );

  mem_timer mem_timer_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (tmr_load),
    .lat_i  (tmr_lat),
    .last_o (tmr_last)
  );

endmodule : issue_ctrl

`default_nettype wire

//--- verification/issue_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl_properties (
  input wire logic           clk_i,
  input wire logic           rst_i,
  input wire logic           dec_valid_i,
  input wire logic           stall_i,
  input wire logic           issue_i,
  input wire issue_pkg::wb_t pipe_wb_i,
  input wire issue_pkg::wb_t mem_wb_i
);

  // **************************************************
  // Issue and writeback rules
  // **************************************************

  issue_needs_free_decode: assert property (
    @(posedge clk_i) disable iff (rst_i) issue_i |-> (dec_valid_i && !stall_i)
  ) else $error("issue_o high without a valid, unstalled descriptor");

  mem_wb_single_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i) mem_wb_i.valid |=> !mem_wb_i.valid
  ) else $error("mem_wb_o valid in two consecutive cycles");

  // A reset edge leaves both writeback ports idle in the following cycle.
  wb_idle_after_reset: assert property (
    @(posedge clk_i) rst_i |=> (!pipe_wb_i.valid && !mem_wb_i.valid)
  ) else $error("writeback valid in the cycle after reset");

endmodule : issue_ctrl_properties

bind issue_ctrl issue_ctrl_properties issue_ctrl_properties_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .dec_valid_i (dec_valid_i),
  .stall_i     (stall_o),
  .issue_i     (issue_o),
  .pipe_wb_i   (pipe_wb_o),
  .mem_wb_i    (mem_wb_o)
);

`default_nettype wire

//--- verification/issue_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl_tb;

  localparam int N_CYCLES   = 600;
  localparam int CLK_PERIOD = 4;
  localparam int TIMEOUT_NS = (N_CYCLES + 60) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic                  dec_valid;
  issue_pkg::dec_instr_t instr;
  logic                  stall;
  logic                  issue;
  issue_pkg::wb_t        pipe_wb;
  issue_pkg::wb_t        mem_wb;

  // Reference state, stage 1 at index 0.
  issue_pkg::ex_stage_t  ex_pipe [issue_pkg::EX_DEPTH];
  issue_pkg::ex_stage_t  alu_slot;
  int                    mem_cnt;  // Cycles left until the access is over, DONE at 1.
  issue_pkg::reg_idx_t   mem_rd;
  logic                  mem_wr;
  int                    issued [4];
  int                    stalls;

  issue_ctrl issue_ctrl_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .dec_valid_i (dec_valid),
    .instr_i     (instr),
    .stall_o     (stall),
    .issue_o     (issue),
    .pipe_wb_o   (pipe_wb),
    .mem_wb_o    (mem_wb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_on_error("Watchdog expired before all cycles were run.");
  end

  // **************************************************
  // Error reporting and compares
  // **************************************************

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_wb(input string name, input issue_pkg::wb_t exp,
                          input issue_pkg::wb_t act);
    if ((act.valid !== exp.valid) || (exp.valid && (act.rd !== exp.rd))) begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, act));
    end
  endtask

  // **************************************************
  // Reference model
  // **************************************************

  function automatic logic reads_reg(input issue_pkg::reg_idx_t src, input logic needed,
                                     input issue_pkg::reg_idx_t rd);
    return needed && (src != '0) && (src == rd);
  endfunction

  function automatic logic writes_source(input issue_pkg::dec_instr_t ins,
                                         input issue_pkg::reg_idx_t rd);
    return reads_reg(ins.rs1, ins.rs1_needed, rd) || reads_reg(ins.rs2, ins.rs2_needed, rd);
  endfunction

  function automatic logic stall_needed(input issue_pkg::dec_instr_t ins);
    logic hold;
    logic pipe_busy;
    hold = 1'b0;
    pipe_busy = 1'b0;
    for (int k = 0; k < issue_pkg::EX_DEPTH; k++) begin
      pipe_busy = pipe_busy || ex_pipe[k].valid;
      if ((k < issue_pkg::EX_DEPTH - 1) && ex_pipe[k].valid && ex_pipe[k].wr &&
          writes_source(ins, ex_pipe[k].rd)) begin
        hold = 1'b1;
      end
    end
    if ((mem_cnt != 0) && mem_wr && writes_source(ins, mem_rd)) begin
      hold = 1'b1;
    end
    if ((ins.iclass == issue_pkg::CLASS_BRANCH) && pipe_busy) hold = 1'b1;
    if ((ins.iclass == issue_pkg::CLASS_ALU) && ex_pipe[issue_pkg::EX_DEPTH-2].valid) begin
      hold = 1'b1;                       // Stage 4 reaches the shared port next cycle.
    end
    if ((ins.iclass == issue_pkg::CLASS_MEM) && (mem_cnt != 0)) hold = 1'b1;
    return hold;
  endfunction

  task automatic expected_writebacks(output issue_pkg::wb_t pipe_exp,
                                     output issue_pkg::wb_t mem_exp);
    pipe_exp = '0;
    mem_exp  = '0;
    if (alu_slot.valid && alu_slot.wr) begin
      pipe_exp.valid = 1'b1;
      pipe_exp.rd    = alu_slot.rd;
    end
    if (ex_pipe[issue_pkg::EX_DEPTH-1].valid && ex_pipe[issue_pkg::EX_DEPTH-1].wr) begin
      pipe_exp.valid = 1'b1;
      pipe_exp.rd    = ex_pipe[issue_pkg::EX_DEPTH-1].rd;
    end
    if ((mem_cnt == 1) && mem_wr) begin
      mem_exp.valid = 1'b1;
      mem_exp.rd    = mem_rd;
    end
  endtask

  task automatic advance_model(input logic iss, input issue_pkg::dec_instr_t ins);
    for (int k = issue_pkg::EX_DEPTH - 1; k > 0; k--) begin
      ex_pipe[k] = ex_pipe[k-1];
    end
    ex_pipe[0].valid = iss && (ins.iclass == issue_pkg::CLASS_EX);
    ex_pipe[0].wr    = ins.rd_wr;
    ex_pipe[0].rd    = ins.rd;
    alu_slot.valid   = iss && (ins.iclass == issue_pkg::CLASS_ALU);
    alu_slot.wr      = ins.rd_wr;
    alu_slot.rd      = ins.rd;
    if (mem_cnt != 0) mem_cnt--;
    if (iss && (ins.iclass == issue_pkg::CLASS_MEM)) begin
      mem_cnt = (ins.mem_lat == '0) ? 2 : int'(ins.mem_lat) + 1;  // Wait cycles plus DONE.
      mem_rd  = ins.rd;
      mem_wr  = ins.rd_wr;
    end
  endtask

  function automatic issue_pkg::dec_instr_t random_instr();
    issue_pkg::dec_instr_t ins;
    ins.rs1        = issue_pkg::reg_idx_t'($urandom_range(7, 0));
    ins.rs2        = issue_pkg::reg_idx_t'($urandom_range(7, 0));
    ins.rs1_needed = ($urandom_range(1, 0) == 1);
    ins.rs2_needed = ($urandom_range(1, 0) == 1);
    ins.rd         = issue_pkg::reg_idx_t'($urandom_range(7, 0));
    ins.rd_wr      = ($urandom_range(3, 0) != 0);
    ins.iclass     = issue_pkg::instr_class_t'($urandom_range(3, 0));
    ins.mem_lat    = issue_pkg::mem_lat_t'($urandom_range(7, 0));
    return ins;
  endfunction

  // **************************************************
  // Stimulus and checking
  // **************************************************

  initial begin
    int unsigned    seed_val;
    logic           held;
    logic           exp_stall;
    logic           exp_issue;
    issue_pkg::wb_t exp_pipe;
    issue_pkg::wb_t exp_mem;
    seed_val  = $urandom(73);
    rst       = 1'b1;
    dec_valid = 1'b0;
    instr     = '0;
    held      = 1'b0;
    stalls    = 0;
    mem_cnt   = 0;
    mem_rd    = '0;
    mem_wr    = 1'b0;
    alu_slot  = '0;
    for (int k = 0; k < issue_pkg::EX_DEPTH; k++) ex_pipe[k] = '0;
    for (int c = 0; c < 4; c++) issued[c] = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
      if (!held) begin                   // A stalled descriptor stays on the inputs.
        dec_valid = ($urandom_range(9, 0) < 8);
        instr     = random_instr();
      end
      #1;
      exp_stall = dec_valid && stall_needed(instr);
      exp_issue = dec_valid && !exp_stall;
      expected_writebacks(exp_pipe, exp_mem);
      check_bit("stall_o", exp_stall, stall);
      check_bit("issue_o", exp_issue, issue);
      check_wb("pipe_wb_o", exp_pipe, pipe_wb);
      check_wb("mem_wb_o", exp_mem, mem_wb);
      held = exp_stall;
      if (exp_stall) stalls++;
      if (exp_issue) issued[instr.iclass]++;
      @(posedge clk);
      advance_model(exp_issue, instr);
      #1;
    end
    if ((issued[0] == 0) || (issued[1] == 0) || (issued[2] == 0) || (issued[3] == 0) ||
        (stalls == 0)) begin
      stop_on_error("Stimulus never issued every class or never produced a stall.");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule : issue_ctrl_tb

`default_nettype wire

//--- issue_ctrl.f
logic/issue_pkg.sv
logic/hazard_unit.sv
logic/exec_tracker.sv
logic/mem_timer.sv
logic/mem_ctrl.sv
logic/issue_ctrl.sv
verification/issue_ctrl_properties.sv
verification/issue_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the issue_ctrl testbench with Verilator, runs it and scans the log.
rm -f sim.log
verilator --binary --timing --assert --top-module issue_ctrl_tb -f issue_ctrl.f \
  -o issue_ctrl_sim || { echo "Build failed."; exit 1; }
./obj_dir/issue_ctrl_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed."; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation did not complete."; exit 1; }
echo "Simulation passed."
exit 0
